// File: Bender.yml
package:
  name: mem_subsys

sources:
  - files:
      - hdl/mem_bus_pkg.sv
      - hdl/bus_decoder.sv
      - hdl/bram.sv
      - hdl/timer.sv
      - hdl/top_mem_subsys.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/tb_top.sv

// File: hdl/bram.sv
`timescale 1ns/10ps

module bram #(
  parameter int unsigned BRAM_DEPTH = 256
) (
  input  logic                  clk,
  input  logic                  arst_n,
  input  mem_bus_pkg::mem_req_t req,
  output mem_bus_pkg::mem_rsp_t rsp
);

  localparam int unsigned IDX_W = $clog2(BRAM_DEPTH);

  logic [31:0]      mem [BRAM_DEPTH];
  logic [IDX_W-1:0] idx;
  logic             acc;
  logic             wr_en;
  logic             ready_q;
  logic [31:0]      rdata_q;

  // Word index, upper address bits dropped so the RAM wraps
  assign idx = req.addr[2 +: IDX_W];

  // New access only when no response is pending for this request
  assign acc   = req.valid & ~ready_q;
  assign wr_en = acc & (|req.wstrb);

  ////////////////////////////////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= acc;  // One-cycle pulse
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////////////

  // Fetches and loads are served alike, instr is not looked at
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[idx] <= mem_bus_pkg::apply_wstrb(mem[idx], req.wdata, req.wstrb);
    end
  end

  always_ff @(posedge clk) begin
    if (acc) begin
      if (wr_en) begin
        rdata_q <= '0;  // Writes return zero
      end else begin
        rdata_q <= mem[idx];
      end
    end
  end

  always_comb begin
    rsp.rdata = rdata_q;
    rsp.ready = ready_q;
  end

endmodule

// File: hdl/bus_decoder.sv
`timescale 1ns/10ps

module bus_decoder #(
  parameter logic [31:0] TIMER_BASE = 32'h0200_0000,
  parameter logic [31:0] TIMER_TOP  = 32'h0200_0010
) (
  input  mem_bus_pkg::mem_req_t req,
  output mem_bus_pkg::mem_req_t bram_req,
  output mem_bus_pkg::mem_req_t timer_req,
  input  mem_bus_pkg::mem_rsp_t bram_rsp,
  input  mem_bus_pkg::mem_rsp_t timer_rsp,
  output mem_bus_pkg::mem_rsp_t rsp
);

  logic timer_sel;

  ////////////////////////////////////////////////////////////////////
  // Request steering
  ////////////////////////////////////////////////////////////////////

  // Timer window is [TIMER_BASE, TIMER_TOP)
  always_comb begin
    timer_sel = (req.addr >= TIMER_BASE) && (req.addr < TIMER_TOP);
  end

  // Both slaves see the same fields, only one sees valid
  always_comb begin
    bram_req        = req;
    timer_req       = req;
    bram_req.valid  = req.valid & ~timer_sel;  // Everything else is RAM
    timer_req.valid = req.valid & timer_sel;
  end

  ////////////////////////////////////////////////////////////////////
  // Response multiplexer
  ////////////////////////////////////////////////////////////////////

  // RAM has priority, then the timer
  always_comb begin
    if (bram_rsp.ready) begin
      rsp = bram_rsp;
    end else if (timer_rsp.ready) begin
      rsp = timer_rsp;
    end else begin
      rsp = '0;  // Idle bus
    end
  end

endmodule

// File: hdl/mem_bus_pkg.sv
package mem_bus_pkg;

  //////////////////////////////////////////////////////////////////////
  // Bus request and response
  //////////////////////////////////////////////////////////////////////

  // One request from the core, 70 bits
  typedef struct packed {
    logic        valid;
    logic        instr;  // Fetch rather than load/store
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;  // Nonzero means write
  } mem_req_t;

  // One response from a slave, 33 bits
  typedef struct packed {
    logic [31:0] rdata;
    logic        ready;
  } mem_rsp_t;

  //////////////////////////////////////////////////////////////////////
  // Machine timer register map
  //////////////////////////////////////////////////////////////////////

  localparam logic [31:0] MTIME_LO_OFS    = 32'h0000_0000;
  localparam logic [31:0] MTIME_HI_OFS    = 32'h0000_0004;
  localparam logic [31:0] MTIMECMP_LO_OFS = 32'h0000_0008;
  localparam logic [31:0] MTIMECMP_HI_OFS = 32'h0000_000C;

  // Merge the strobed bytes of wdata into an old word
  function automatic logic [31:0] apply_wstrb(
    input logic [31:0] old_word,
    input logic [31:0] wdata,
    input logic [3:0]  wstrb
  );
    logic [31:0] merged;
    merged = old_word;
    for (int b = 0; b < 4; b++) begin
      if (wstrb[b]) begin
        merged[8*b +: 8] = wdata[8*b +: 8];
      end
    end
    return merged;
  endfunction

endpackage

// File: hdl/timer.sv
`timescale 1ns/10ps

module timer (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  rtc,
  input  mem_bus_pkg::mem_req_t req,
  output mem_bus_pkg::mem_rsp_t rsp,
  output logic                  irpt
);

  // Register select codes taken from the byte offsets
  localparam logic [1:0] SEL_MTIME_LO = mem_bus_pkg::MTIME_LO_OFS[3:2];
  localparam logic [1:0] SEL_MTIME_HI = mem_bus_pkg::MTIME_HI_OFS[3:2];
  localparam logic [1:0] SEL_CMP_LO   = mem_bus_pkg::MTIMECMP_LO_OFS[3:2];
  localparam logic [1:0] SEL_CMP_HI   = mem_bus_pkg::MTIMECMP_HI_OFS[3:2];

  logic        rtc_s1;
  logic        rtc_s2;
  logic        rtc_d;
  logic        tick;
  logic [63:0] mtime;
  logic [63:0] mtimecmp;
  logic [1:0]  sel;
  logic        acc;
  logic        wr_en;
  logic [31:0] cur_word;
  logic        ready_q;
  logic [31:0] rdata_q;
  logic        irpt_q;

  //////////////////////////////////////////////////////////////////////
  // rtc synchroniser and edge detect
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rtc_s1 <= 1'b0;
      rtc_s2 <= 1'b0;
      rtc_d  <= 1'b0;
    end else begin
      rtc_s1 <= rtc;
      rtc_s2 <= rtc_s1;
      rtc_d  <= rtc_s2;
    end
  end

  assign tick = rtc_s2 & ~rtc_d;  // Rising edge, one clock wide

  //////////////////////////////////////////////////////////////////////
  // Bus access
  //////////////////////////////////////////////////////////////////////

  assign sel   = req.addr[3:2];
  assign acc   = req.valid & ~ready_q;
  assign wr_en = acc & (|req.wstrb);

  always_comb begin
    case (sel)
      SEL_MTIME_LO: cur_word = mtime[31:0];
      SEL_MTIME_HI: cur_word = mtime[63:32];
      SEL_CMP_LO:   cur_word = mtimecmp[31:0];
      default:      cur_word = mtimecmp[63:32];
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= acc;
    end
  end

  always_ff @(posedge clk) begin
    if (acc) begin
      rdata_q <= wr_en ? '0 : cur_word;  // Writes return zero
    end
  end

  //////////////////////////////////////////////////////////////////////
  // mtime and mtimecmp
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mtime <= '0;
    end else if (wr_en && sel == SEL_MTIME_LO) begin
      mtime[31:0] <= mem_bus_pkg::apply_wstrb(mtime[31:0], req.wdata, req.wstrb);
    end else if (wr_en && sel == SEL_MTIME_HI) begin
      mtime[63:32] <= mem_bus_pkg::apply_wstrb(mtime[63:32], req.wdata, req.wstrb);
    end else if (tick) begin
      mtime <= mtime + 64'd1;  // Write wins over the tick
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mtimecmp <= '1;  // No interrupt out of reset
    end else if (wr_en && sel == SEL_CMP_LO) begin
      mtimecmp[31:0] <= mem_bus_pkg::apply_wstrb(mtimecmp[31:0], req.wdata, req.wstrb);
    end else if (wr_en && sel == SEL_CMP_HI) begin
      mtimecmp[63:32] <= mem_bus_pkg::apply_wstrb(mtimecmp[63:32], req.wdata, req.wstrb);
    end
  end

  // Interrupt level, one clock behind the registers
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      irpt_q <= 1'b0;
    end else begin
      irpt_q <= (mtime >= mtimecmp);
    end
  end

  assign irpt = irpt_q;

  always_comb begin
    rsp.rdata = rdata_q;
    rsp.ready = ready_q;
  end

endmodule

// File: hdl/top_mem_subsys.sv
`timescale 1ns/10ps

module top_mem_subsys #(
  parameter int unsigned BRAM_DEPTH = 256,
  parameter logic [31:0] TIMER_BASE = 32'h0200_0000,
  parameter logic [31:0] TIMER_TOP  = 32'h0200_0010
) (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  rtc,
  input  mem_bus_pkg::mem_req_t req,
  output mem_bus_pkg::mem_rsp_t rsp,
  output logic                  timer_irpt
);

  mem_bus_pkg::mem_req_t bram_req;
  mem_bus_pkg::mem_rsp_t bram_rsp;
  mem_bus_pkg::mem_req_t timer_req;
  mem_bus_pkg::mem_rsp_t timer_rsp;

  // Address decode and response mux
  bus_decoder #(
    .TIMER_BASE (TIMER_BASE),
    .TIMER_TOP  (TIMER_TOP)
  ) bus_decoder_comp (
    .req       (req),
    .bram_req  (bram_req),
    .timer_req (timer_req),
    .bram_rsp  (bram_rsp),
    .timer_rsp (timer_rsp),
    .rsp       (rsp)
  );

  bram #(
    .BRAM_DEPTH (BRAM_DEPTH)
  ) bram_comp (
    .clk    (clk),
    .arst_n (arst_n),
    .req    (bram_req),
    .rsp    (bram_rsp)
  );

  timer timer_comp (
    .clk    (clk),
    .arst_n (arst_n),
    .rtc    (rtc),
    .req    (timer_req),
    .rsp    (timer_rsp),
    .irpt   (timer_irpt)  // Straight to the core
  );

endmodule

// File: tb.f
+incdir+include
hdl/mem_bus_pkg.sv
hdl/bus_decoder.sv
hdl/bram.sv
hdl/timer.sv
hdl/top_mem_subsys.sv
tests/tb_top.sv

// File: tests/mem_golden.txt
// op addr wdata wstrb expected, all hex; T takes its pulse count from wdata
// W write, R read and compare rdata, T rtc pulses, I compare timer_irpt
# reset_state
I 00000000 00000000 0 00000000
R 02000000 00000000 0 00000000
R 0200000C 00000000 0 FFFFFFFF
# ram_write_read
W 00000000 11223344 F 00000000
W 00000004 A5A5A5A5 F 00000000
W 00000100 DEADBEEF F 00000000
W 000003FC 0BADF00D F 00000000
R 00000000 00000000 0 11223344
R 00000004 00000000 0 A5A5A5A5
R 00000100 00000000 0 DEADBEEF
R 000003FC 00000000 0 0BADF00D
# byte_strobes
W 00000020 11223344 F 00000000
W 00000020 000000AA 1 00000000
R 00000020 00000000 0 112233AA
W 00000020 0000BB00 2 00000000
W 00000020 CCDD0000 C 00000000
R 00000020 00000000 0 CCDDBBAA
W 00000420 00EE0000 4 00000000
R 00000020 00000000 0 CCEEBBAA
R 00000820 00000000 0 CCEEBBAA
W 00000024 55667788 F 00000000
W 00000024 99000000 8 00000000
R 00000424 00000000 0 99667788
# timer_regs
W 00000000 CAFEBABE F 00000000
W 00000008 12345678 F 00000000
W 02000000 00001000 F 00000000
W 02000004 00000002 F 00000000
W 02000008 00002000 F 00000000
W 0200000C 00000003 F 00000000
R 02000000 00000000 0 00001000
R 02000004 00000000 0 00000002
R 02000008 00000000 0 00002000
R 0200000C 00000000 0 00000003
R 00000000 00000000 0 CAFEBABE
R 00000008 00000000 0 12345678
# rtc_count
W 02000004 00000000 F 00000000
W 02000000 00000010 F 00000000
T 00000000 00000003 0 00000000
R 02000000 00000000 0 00000013
R 02000004 00000000 0 00000000
W 02000000 FFFFFFFE F 00000000
T 00000000 00000004 0 00000000
R 02000000 00000000 0 00000002
R 02000004 00000000 0 00000001
# interrupt
I 00000000 00000000 0 00000000
W 0200000C 00000000 F 00000000
I 00000000 00000000 0 00000001
W 0200000C 00000001 F 00000000
I 00000000 00000000 0 00000000
W 02000008 00000002 F 00000000
I 00000000 00000000 0 00000001
W 02000008 00000003 F 00000000
I 00000000 00000000 0 00000000

// File: include/tb_tasks.svh
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// Compare one value against its expected value
task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
  n_checks++;
  if (got !== exp) begin
    n_errors++;
    $display("error %s got %h expected %h", name, got, exp);
  end
endtask

// Drive one request and wait for its ready pulse
task automatic bus_xfer(
  input  logic [31:0] addr,
  input  logic [31:0] wdata,
  input  logic [3:0]  wstrb,
  output logic [31:0] rdata
);
  int waited;
  waited = 0;
  @(posedge clk);
  #2;
  req = '{valid: 1'b1, instr: 1'b0, addr: addr, wdata: wdata, wstrb: wstrb};
  do begin
    @(posedge clk);
    #1;
    waited++;
  end while (!rsp.ready && waited < 8);
  if (!rsp.ready) begin
    n_errors++;
    $display("error no response came from address %h", addr);
  end
  rdata = rsp.rdata;
  // Valid is still held at the next edge and must not bring a second ready
  @(posedge clk);
  #1;
  check("rsp.ready", rsp.ready, 64'h0);
  #1;
  req = '0;
endtask

task automatic bus_write(input logic [31:0] addr, input logic [31:0] wdata,
                         input logic [3:0] wstrb);
  logic [31:0] unused_rdata;
  bus_xfer(addr, wdata, wstrb, unused_rdata);
endtask

task automatic bus_read(input logic [31:0] addr, output logic [31:0] rdata);
  bus_xfer(addr, 32'h0, 4'h0, rdata);
endtask

// Apply n rtc pulses with each level held 4 clocks and let the count settle
task automatic rtc_ticks(input int n);
  repeat (n) begin
    @(posedge clk);
    #2;
    rtc = 1'b1;
    repeat (4) @(posedge clk);
    #2;
    rtc = 1'b0;
    repeat (3) @(posedge clk);
  end
  repeat (4) @(posedge clk);
endtask

`endif

// File: tests/tb_top.sv
`timescale 1ns/10ps

module tb_top;

  logic                  clk;
  logic                  arst_n;
  logic                  rtc;
  mem_bus_pkg::mem_req_t req;
  mem_bus_pkg::mem_rsp_t rsp;
  logic                  timer_irpt;

  int    n_checks;
  int    n_errors;
  string lines[$];
  bit    loaded;
  string cur_test;
  int    test_err_base;

  `include "tb_tasks.svh"

  top_mem_subsys #(
    .BRAM_DEPTH (256),
    .TIMER_BASE (32'h0200_0000),
    .TIMER_TOP  (32'h0200_0010)
  ) UUT (
    .clk        (clk),
    .arst_n     (arst_n),
    .rtc        (rtc),
    .req        (req),
    .rsp        (rsp),
    .timer_irpt (timer_irpt)
  );

  always #20 clk = ~clk;  // 40 ns period

  //////////////////////////////////////////////////////////////////////
  // Watchdog with 40 clocks per golden line
  //////////////////////////////////////////////////////////////////////

  initial begin
    longint timeout_ns;
    wait (loaded);
    timeout_ns = longint'(lines.size()) * 40 * 40;
    #(timeout_ns);
    $display("run timed out after %0d ns", timeout_ns);
    $display("sim failed");
    $finish;
  end

  // Closes the current test with its own error count
  function automatic void report_test();
    if (cur_test != "") begin
      $display("test %s: %0d errors", cur_test, n_errors - test_err_base);
    end
  endfunction

  // One golden line holds a test name, a note or a bus operation
  task automatic run_vector(input string line);
    byte         op;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic [31:0] exp;
    logic [31:0] rdata;
    int          cnt;
    string       name;
    if (line.len() < 2 || line[0] == "/") begin
      return;  // Blank or column notes
    end
    if (line[0] == "#") begin
      report_test();
      cnt = $sscanf(line, "# %s", name);
      cur_test = name;
      test_err_base = n_errors;
      return;
    end
    cnt = $sscanf(line, "%c %h %h %h %h", op, addr, wdata, wstrb, exp);
    if (cnt != 5) begin
      n_errors++;
      $display("golden line could not be parsed: %s", line);
      return;
    end
    repeat ($urandom_range(3, 0)) @(posedge clk);
    case (op)
      "W": bus_write(addr, wdata, wstrb);
      "R": begin
        bus_read(addr, rdata);
        check("rdata", rdata, exp);
      end
      "T": rtc_ticks(int'(wdata));  // Pulse count in the wdata column
      "I": begin
        @(posedge clk);  // irpt is one clock behind the registers
        #1;
        check("timer_irpt", timer_irpt, exp[0]);
      end
      default: begin
        n_errors++;
        $display("golden line has an unknown opcode: %s", line);
      end
    endcase
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int    fd;
    string line;
    clk           = 1'b0;
    arst_n        = 1'b0;
    rtc           = 1'b0;
    req           = '0;
    n_checks      = 0;
    n_errors      = 0;
    loaded        = 1'b0;
    cur_test      = "";
    test_err_base = 0;
    void'($urandom(12773));

    fd = $fopen("tests/mem_golden.txt", "r");
    if (fd == 0) begin
      n_errors++;
      $display("could not open the golden file tests/mem_golden.txt");
    end else begin
      while (!$feof(fd)) begin
        if ($fgets(line, fd) != 0) begin
          lines.push_back(line);
        end
      end
      $fclose(fd);
      loaded = (lines.size() > 0);
      if (!loaded) begin
        n_errors++;
        $display("the golden file tests/mem_golden.txt holds no lines");
      end
    end

    repeat (5) @(posedge clk);
    #2;
    arst_n = 1'b1;

    foreach (lines[i]) begin
      run_vector(lines[i]);
    end
    report_test();

    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule
